// File: rtl/nmsedec_cfg.svh
`ifndef NMSEDEC_CFG_SVH
`define NMSEDEC_CFG_SVH

// Lane group shape
`define NMSEDEC_LANES 4
`define NMSEDEC_W 17

// Per-pass sum width, headroom for long code blocks
`define ACC_W 26

// Control delays, counted in unstalled edges
`define START_DELAY 4
`define STOP_DELAY 3

// Result window length in cycles
`define OUT_VLD_CYCLES 4

`endif

// File: rtl/nmsedec_pkg.sv
`include "nmsedec_cfg.svh"

package nmsedec_pkg;

  // One-hot pass code
  typedef logic [2:0] pass_code_t;

  localparam pass_code_t code_sp = 3'b001;
  localparam pass_code_t code_mrp = 3'b010;
  localparam pass_code_t code_cp = 3'b100;

  typedef struct packed {
    logic signed [`NMSEDEC_W-1:0] sample;
    pass_code_t                   code;
    logic                         add_vld;
  } lane_t;

  typedef lane_t [`NMSEDEC_LANES-1:0] lane_group_t;

  typedef logic [$clog2(`NMSEDEC_LANES)-1:0] lane_sel_t;

  typedef logic signed [`ACC_W-1:0] acc_t;

  // Significance, refinement and cleanup sums
  typedef struct packed {
    acc_t sp;
    acc_t mrp;
    acc_t cp;
  } pass_sums_t;

endpackage

// File: rtl/pass_ctrl_pkg.sv
package pass_ctrl_pkg;

  // Encoding 2'b11 is unused
  typedef enum logic [1:0] {
    pass_idle = 2'b00,
    pass_cal  = 2'b01,
    pass_wait = 2'b10
  } pass_state_t;

  // Latched on cal entry
  typedef struct packed {
    logic [3:0] mul_factor;
    logic [3:0] count_bp;
  } pass_factors_t;

endpackage

// File: rtl/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk_pass_pre,
  input  logic     rst,
  input  logic     stall,
  input  payload_t d,
  output payload_t q
);

  payload_t stage [DEPTH];

  // Whole line holds while stalled
  always_ff @(posedge clk_pass_pre or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else if (!stall) begin
      stage[0] <= d;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign q = stage[DEPTH-1];

endmodule

// File: rtl/sample_capture.sv
`timescale 1ns/1ps
`include "nmsedec_cfg.svh"

module sample_capture (
  input  logic                     clk_pass_pre,
  input  logic                     rst,
  input  logic                     stall,
  input  logic                     flush_clr,
  input  nmsedec_pkg::lane_group_t lanes,
  output nmsedec_pkg::lane_group_t group
);

  always_ff @(posedge clk_pass_pre or negedge rst) begin
    if (!rst) begin
      group <= '0;
    end else begin
      for (int i = 0; i < `NMSEDEC_LANES; i++) begin
        if (!stall) begin
          group[i].sample <= lanes[i].sample;
        end
        // Flush wins over a new load, even when stalled
        if (flush_clr) begin
          group[i].code <= '0;
          group[i].add_vld <= 1'b0;
        end else if (!stall) begin
          group[i].code <= lanes[i].code;
          group[i].add_vld <= lanes[i].add_vld;
        end
      end
    end
  end

endmodule

// File: rtl/pass_ctrl.sv
`timescale 1ns/1ps
`include "nmsedec_cfg.svh"

module pass_ctrl (
  input  logic                         clk_pass_pre,
  input  logic                         rst,
  input  logic                         stall,
  input  logic                         start_dly,
  input  logic                         stop_dly,
  input  pass_ctrl_pkg::pass_factors_t factors_in,
  output logic                         acc_en,
  output nmsedec_pkg::lane_sel_t       lane_sel,
  output logic                         flush_clr,
  output logic                         cal_out_vld,
  output pass_ctrl_pkg::pass_factors_t factors
);
  import pass_ctrl_pkg::*;

  localparam int WIN_W = $clog2(`OUT_VLD_CYCLES);

  pass_state_t      state;
  pass_state_t      state_n;
  logic             was_cal;
  logic             win_start;
  logic             win_busy;
  logic [WIN_W-1:0] win_cnt;

  // First cycle in wait after cal
  assign win_start = (state == pass_wait) && was_cal;
  assign win_busy = win_start || cal_out_vld;

  always_comb begin
    state_n = state;
    case (state)
      pass_idle: begin
        if (start_dly) begin
          state_n = pass_cal;
        end
      end
      pass_cal: begin
        if (stop_dly) begin
          state_n = pass_wait;
        end
      end
      pass_wait: begin
        // Hold wait until the window is out
        if (!stop_dly && !win_busy) begin
          state_n = pass_cal;
        end
      end
      default: begin
        state_n = pass_idle;
      end
    endcase
  end

  always_ff @(posedge clk_pass_pre or negedge rst) begin
    if (!rst) begin
      state <= pass_idle;
      was_cal <= 1'b0;
      factors <= '0;
      lane_sel <= '0;
    end else begin
      state <= state_n;
      was_cal <= (state == pass_cal);
      if ((state == pass_cal) && !was_cal) begin
        factors <= factors_in;
      end
      if (acc_en) begin
        lane_sel <= lane_sel + 1'b1;
      end
    end
  end

  assign acc_en = (state == pass_cal) && !stall;

  always_ff @(posedge clk_pass_pre or negedge rst) begin
    if (!rst) begin
      cal_out_vld <= 1'b0;
      win_cnt <= '0;
    end else if (win_start) begin
      cal_out_vld <= 1'b1;
      win_cnt <= '0;
    end else if (flush_clr) begin
      cal_out_vld <= 1'b0;
    end else if (cal_out_vld) begin
      win_cnt <= win_cnt + 1'b1;
    end
  end

  // Last window cycle, clears take effect on the closing edge
  assign flush_clr = cal_out_vld && (win_cnt == WIN_W'(`OUT_VLD_CYCLES - 1));

  a_state_legal: assert property (
    @(posedge clk_pass_pre) disable iff (!rst)
    state inside {pass_idle, pass_cal, pass_wait}
  );

  a_vld_in_wait: assert property (
    @(posedge clk_pass_pre) disable iff (!rst)
    cal_out_vld |-> (state == pass_wait)
  );

endmodule

// File: rtl/distortion_accum.sv
`timescale 1ns/1ps

module distortion_accum (
  input  logic                     clk_pass_pre,
  input  logic                     rst,
  input  logic                     acc_en,
  input  logic                     clear,
  input  logic                     flush_clr,
  input  nmsedec_pkg::lane_group_t group,
  input  nmsedec_pkg::lane_sel_t   lane_sel,
  output nmsedec_pkg::pass_sums_t  sums
);
  import nmsedec_pkg::*;

  lane_t cur;
  acc_t  ext;

  assign cur = group[lane_sel];

  // Signed source, so the cast sign-extends
  assign ext = acc_t'(cur.sample);

  always_ff @(posedge clk_pass_pre or negedge rst) begin
    if (!rst) begin
      sums <= '0;
    end else if (clear || flush_clr) begin
      sums <= '0;
    end else if (acc_en) begin
      case (cur.code)
        code_sp: begin
          if (cur.add_vld) begin
            sums.sp <= sums.sp + ext;
          end
        end
        // Refinement adds whatever add_vld says
        code_mrp: begin
          sums.mrp <= sums.mrp + ext;
        end
        code_cp: begin
          if (cur.add_vld) begin
            sums.cp <= sums.cp + ext;
          end
        end
        default: begin
          sums <= sums;
        end
      endcase
    end
  end

endmodule

// File: rtl/pass_error_pre.sv
`timescale 1ns/1ps
`include "nmsedec_cfg.svh"

module pass_error_pre (
  input  logic                         clk_pass_pre,
  input  logic                         rst,
  input  nmsedec_pkg::lane_group_t     lanes,
  input  logic                         start,
  input  logic                         stop,
  input  logic                         stall,
  input  logic                         clear,
  input  pass_ctrl_pkg::pass_factors_t factors_in,
  output nmsedec_pkg::pass_sums_t      sums,
  output pass_ctrl_pkg::pass_factors_t factors,
  output logic                         cal_out_vld
);
  import nmsedec_pkg::*;

  logic        start_dly;
  logic        stop_dly;
  logic        acc_en;
  logic        flush_clr;
  lane_group_t group;
  lane_sel_t   lane_sel;

  sample_capture sample_capture_inst (
    .clk_pass_pre (clk_pass_pre),
    .rst          (rst),
    .stall        (stall),
    .flush_clr    (flush_clr),
    .lanes        (lanes),
    .group        (group)
  );

  delay_line #(
    .payload_t (logic),
    .DEPTH     (`START_DELAY)
  ) start_delay_inst (
    .clk_pass_pre (clk_pass_pre),
    .rst          (rst),
    .stall        (stall),
    .d            (start),
    .q            (start_dly)
  );

  delay_line #(
    .payload_t (logic),
    .DEPTH     (`STOP_DELAY)
  ) stop_delay_inst (
    .clk_pass_pre (clk_pass_pre),
    .rst          (rst),
    .stall        (stall),
    .d            (stop),
    .q            (stop_dly)
  );

  pass_ctrl pass_ctrl_inst (
    .clk_pass_pre (clk_pass_pre),
    .rst          (rst),
    .stall        (stall),
    .start_dly    (start_dly),
    .stop_dly     (stop_dly),
    .factors_in   (factors_in),
    .acc_en       (acc_en),
    .lane_sel     (lane_sel),
    .flush_clr    (flush_clr),
    .cal_out_vld  (cal_out_vld),
    .factors      (factors)
  );

  distortion_accum distortion_accum_inst (
    .clk_pass_pre (clk_pass_pre),
    .rst          (rst),
    .acc_en       (acc_en),
    .clear        (clear),
    .flush_clr    (flush_clr),
    .group        (group),
    .lane_sel     (lane_sel),
    .sums         (sums)
  );

endmodule

// File: dv/tb_pass_error_pre.sv
`timescale 1ns/1ps
`include "nmsedec_cfg.svh"

module tb_pass_error_pre;
  import nmsedec_pkg::*;
  import pass_ctrl_pkg::*;

  logic          clk_pass_pre;
  logic          rst;
  lane_group_t   lanes;
  logic          start;
  logic          stop;
  logic          stall;
  logic          clear;
  pass_factors_t factors_in;
  pass_sums_t    sums;
  pass_factors_t factors;
  logic          cal_out_vld;

  // Trace segments, each held for rep cycles
  int            rep_q[$];
  logic [3:0]    ctl_q[$];
  pass_factors_t fac_q[$];
  lane_group_t   grp_q[$];
  string         name_q[$];
  pass_sums_t    exp_q[$];
  pass_factors_t expf_q[$];

  int value_errs = 0;
  int other_errs = 0;
  int total_cycles = 0;
  int limit = 100000;
  int cycle_cnt = 0;
  int win_idx = 0;
  int win_len = 0;
  logic prev_vld = 1'b0;

  // Reference model state
  logic [3:0]    m_start_sr = '0;
  logic [2:0]    m_stop_sr = '0;
  int            m_state = 0;
  int            m_sel = 0;
  int            m_win = 0;
  int            m_idx = 0;
  logic          m_fac_pending = 1'b0;
  lane_group_t   m_group = '0;
  pass_sums_t    m_sums = '0;
  pass_factors_t m_fac = '0;

  pass_error_pre pass_error_pre_inst (
    .clk_pass_pre (clk_pass_pre),
    .rst          (rst),
    .lanes        (lanes),
    .start        (start),
    .stop         (stop),
    .stall        (stall),
    .clear        (clear),
    .factors_in   (factors_in),
    .sums         (sums),
    .factors      (factors),
    .cal_out_vld  (cal_out_vld)
  );

  initial begin
    clk_pass_pre = 1'b0;
    forever #20 clk_pass_pre = ~clk_pass_pre;
  end

  task automatic check_sums(input string name, input pass_sums_t exp, input pass_sums_t act);
    if (act !== exp) begin
      value_errs++;
      $display("FAIL %s sums expected sp=%0d mrp=%0d cp=%0d actual sp=%0d mrp=%0d cp=%0d",
               name, exp.sp, exp.mrp, exp.cp, act.sp, act.mrp, act.cp);
    end
  endtask

  task automatic check_factors(input string name, input pass_factors_t exp,
                               input pass_factors_t act);
    if (act !== exp) begin
      value_errs++;
      $display("FAIL %s factors expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_window(input string name, input int exp, input int act);
    if (act != exp) begin
      value_errs++;
      $display("FAIL %s window length expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic load_trace();
    int    fd;
    int    n;
    int    rep, st, sto, stl, clr, fc, sp, mrp, cp;
    int    s[4];
    int    c[4];
    int    v[4];
    string line;
    logic [8*24-1:0] name;
    lane_group_t g;
    pass_sums_t  es;
    fd = $fopen("dv/pass_error_trace.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("Cannot open the trace file dv/pass_error_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 0 && line.getc(0) == "S") begin
          n = $sscanf(line, "S %d %d %d %d %d %h %d %d %d %d %d %d %d %d %d %d %d %d",
                      rep, st, sto, stl, clr, fc, s[0], c[0], v[0], s[1], c[1], v[1],
                      s[2], c[2], v[2], s[3], c[3], v[3]);
          for (int i = 0; i < 4; i++) begin
            g[i].sample = s[i];
            g[i].code = c[i];
            g[i].add_vld = v[i];
          end
          rep_q.push_back(rep);
          ctl_q.push_back({st[0], sto[0], stl[0], clr[0]});
          fac_q.push_back(fc);
          grp_q.push_back(g);
          total_cycles += rep;
        end else if (line.len() > 0 && line.getc(0) == "E") begin
          n = $sscanf(line, "E %s %d %d %d %h", name, sp, mrp, cp, fc);
          name_q.push_back($sformatf("%0s", name));
          es.sp = sp;
          es.mrp = mrp;
          es.cp = cp;
          exp_q.push_back(es);
          expf_q.push_back(fc);
        end
      end
      $fclose(fd);
    end
  endtask

  // Accumulation and window rules applied once per rising edge
  task automatic model_step();
    int    w;
    int    val;
    lane_t ln;
    w = m_win;
    ln = m_group[m_sel];
    val = ln.sample;
    if (clear || w == 1) begin
      m_sums = '0;
    end else if (m_state == 1 && !stall) begin
      if (ln.code == 3'b001 && ln.add_vld) m_sums.sp = m_sums.sp + acc_t'(val);
      if (ln.code == 3'b010) m_sums.mrp = m_sums.mrp + acc_t'(val);
      if (ln.code == 3'b100 && ln.add_vld) m_sums.cp = m_sums.cp + acc_t'(val);
    end
    if (m_state == 1 && !stall) m_sel = (m_sel + 1) % 4;
    if (m_fac_pending) m_fac = factors_in;
    m_fac_pending = 1'b0;
    if (w == 5) begin
      if (m_idx >= exp_q.size() || m_sums !== exp_q[m_idx] || m_fac !== expf_q[m_idx]) begin
        other_errs++;
        $display("Reference model disagrees with the trace expected values of window %0d",
                 m_idx);
      end
      m_idx++;
    end
    if (w > 0) m_win = w - 1;
    if (m_state == 0 && m_start_sr[3]) begin
      m_state = 1;
      m_fac_pending = 1'b1;
    end else if (m_state == 1 && m_stop_sr[2]) begin
      m_state = 2;
      m_win = 5;
    end else if (m_state == 2 && w == 0 && !m_stop_sr[2]) begin
      m_state = 1;
      m_fac_pending = 1'b1;
    end
    if (!stall) m_group = lanes;
    if (w == 1) begin
      for (int i = 0; i < 4; i++) begin
        m_group[i].code = '0;
        m_group[i].add_vld = 1'b0;
      end
    end
    if (!stall) begin
      m_start_sr = {m_start_sr[2:0], start};
      m_stop_sr = {m_stop_sr[1:0], stop};
    end
  endtask

  task automatic observe();
    if (cal_out_vld) begin
      if (!prev_vld) begin
        win_len = 0;
        if (win_idx < exp_q.size()) begin
          check_sums(name_q[win_idx], exp_q[win_idx], sums);
          check_factors(name_q[win_idx], expf_q[win_idx], factors);
        end else begin
          other_errs++;
          $display("Result window %0d appeared with no expected entry", win_idx);
        end
        win_idx++;
      end else if (win_idx <= exp_q.size()) begin
        check_sums("window_hold", exp_q[win_idx-1], sums);
      end
      win_len++;
    end else if (prev_vld) begin
      check_window("window", `OUT_VLD_CYCLES, win_len);
      check_sums("after_window", '0, sums);
    end
    prev_vld = cal_out_vld;
  endtask

  initial begin : watchdog
    while (cycle_cnt < limit) begin
      @(posedge clk_pass_pre);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles", cycle_cnt);
    $display("Verification failed");
    $finish;
  end

  initial begin
    rst = 1'b0;
    lanes = '0;
    start = 1'b0;
    stop = 1'b0;
    stall = 1'b0;
    clear = 1'b0;
    factors_in = '0;
    load_trace();
    limit = (total_cycles + 16) * 2;
    repeat (16) @(negedge clk_pass_pre);
    rst = 1'b1;
    check_sums("reset", '0, sums);
    check_factors("reset", '0, factors);
    if (cal_out_vld !== 1'b0) begin
      other_errs++;
      $display("cal_out_vld is high right after reset");
    end
    for (int k = 0; k < rep_q.size(); k++) begin
      for (int r = 0; r < rep_q[k]; r++) begin
        {start, stop, stall, clear} = ctl_q[k];
        factors_in = fac_q[k];
        lanes = grp_q[k];
        @(posedge clk_pass_pre);
        model_step();
        @(negedge clk_pass_pre);
        observe();
      end
    end
    if (win_idx != exp_q.size() || m_idx != exp_q.size()) begin
      other_errs++;
      $display("Expected %0d result windows, DUT gave %0d and the model %0d",
               exp_q.size(), win_idx, m_idx);
    end
    $display("Errors: value %0d, other %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: dv/pass_error_trace.txt
# S rep start stop stall clear factors_in(hex), then per lane 0..3: sample code add_vld
# E test_name sp mrp cp factors(hex)
S 6 1 0 0 0 5a 100 1 1 -37 2 0 250 4 0 -5 3 1
S 3 1 0 0 0 11 100 1 1 -37 2 0 250 4 0 -5 3 1
S 1 1 1 0 0 11 100 1 1 -37 2 0 250 4 0 -5 3 1
S 3 1 0 0 0 11 100 1 1 -37 2 0 250 4 0 -5 3 1
E routing_a 200 -74 0 5a
S 6 1 0 0 0 11 -1000 4 1 7 1 0 300 2 1 -65536 1 1
S 1 1 0 0 0 3c -1000 4 1 7 1 0 300 2 1 -65536 1 1
S 3 1 0 0 0 22 -1000 4 1 7 1 0 300 2 1 -65536 1 1
S 1 1 1 0 0 22 -1000 4 1 7 1 0 300 2 1 -65536 1 1
S 9 1 0 0 0 22 -1000 4 1 7 1 0 300 2 1 -65536 1 1
E routing_b -131072 600 -2000 3c
S 1 1 0 0 0 96 -1000 4 1 7 1 0 300 2 1 -65536 1 1
S 1 1 0 0 0 44 -1000 4 1 7 1 0 300 2 1 -65536 1 1
S 3 1 0 1 0 44 -1000 4 1 7 1 0 300 2 1 -65536 1 1
S 2 1 0 0 0 44 -1000 4 1 7 1 0 300 2 1 -65536 1 1
S 1 1 1 0 0 44 -1000 4 1 7 1 0 300 2 1 -65536 1 1
S 4 1 0 0 0 44 -1000 4 1 7 1 0 300 2 1 -65536 1 1
E stall -131072 600 -2000 96
S 5 1 0 0 0 44 100 1 1 -37 2 0 250 4 0 -5 3 1
S 1 1 0 0 0 e7 100 1 1 -37 2 0 250 4 0 -5 3 1
S 2 1 0 0 0 55 100 1 1 -37 2 0 250 4 0 -5 3 1
S 1 1 0 0 1 55 100 1 1 -37 2 0 250 4 0 -5 3 1
S 4 1 0 0 0 55 100 1 1 -37 2 0 250 4 0 -5 3 1
S 1 1 1 0 0 55 100 1 1 -37 2 0 250 4 0 -5 3 1
S 11 1 0 0 0 55 100 1 1 -37 2 0 250 4 0 -5 3 1
E clear 200 -74 0 e7

// File: all.f
+incdir+rtl
rtl/nmsedec_pkg.sv
rtl/pass_ctrl_pkg.sv
rtl/delay_line.sv
rtl/sample_capture.sv
rtl/pass_ctrl.sv
rtl/distortion_accum.sv
rtl/pass_error_pre.sv
dv/tb_pass_error_pre.sv

// File: Bender.yml
package:
  name: pass_error_pre

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/nmsedec_pkg.sv
      - rtl/pass_ctrl_pkg.sv
      - rtl/delay_line.sv
      - rtl/sample_capture.sv
      - rtl/pass_ctrl.sv
      - rtl/distortion_accum.sv
      - rtl/pass_error_pre.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tb_pass_error_pre.sv
